// ==== fpu_slice.f ====
+incdir+src
+incdir+sim
src/fpu_slice_pkg.sv
src/fpu_op_decode.sv
src/fpu_issue_buffer.sv
src/fpu_noncomp_unit.sv
src/fpu_slice_top.sv
sim/tb_fpu_slice.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the fpu_slice testbench with Verilator and runs it once
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_fpu_slice \
    -f fpu_slice.f --Mdir obj_dir || { echo "Build failed"; exit 1; }
out="$(./obj_dir/Vtb_fpu_slice 2>&1)"
echo "$out"
echo "$out" | grep -qxF '** PASS **' && exit 0 || exit 1

// ==== sim/tb_fpu_ref.svh ====
// ----------------------------
// Expected results for the FP slice testbench
// Included inside the testbench module after the package import
// FP32 only, NaN payloads pass through untouched
// ----------------------------
`ifndef TB_FPU_REF_SVH
`define TB_FPU_REF_SVH

function automatic logic is_nan(input logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
endfunction

function automatic logic is_snan(input logic [31:0] x);
    return is_nan(x) && !x[22];  // Quiet bit clear
endfunction

function automatic logic is_zero(input logic [31:0] x);
    return x[30:0] == 31'd0;
endfunction

// Unsigned key that sorts like the FP value, -0 just below +0
function automatic logic [31:0] order_key(input logic [31:0] x);
    return x[31] ? ~x : (x | 32'h8000_0000);
endfunction

function automatic logic [9:0] class_mask(input logic [31:0] x);
    logic [9:0] m;
    m = '0;
    if (is_nan(x))                    m[x[22] ? 9 : 8] = 1'b1;
    else if (x[30:0] == 31'h7f800000) m[x[31] ? 0 : 7] = 1'b1;  // Infinity
    else if (is_zero(x))              m[x[31] ? 3 : 4] = 1'b1;
    else if (x[30:23] == 8'd0)        m[x[31] ? 2 : 5] = 1'b1;  // Subnormal
    else                              m[x[31] ? 1 : 6] = 1'b1;
    return m;
endfunction

function automatic logic [31:0] expected_result(input fu_op_e op, input logic [31:0] a,
                                                input logic [31:0] b, input logic [2:0] rm);
    logic [31:0] r;
    logic        lt, eq, nan;
    r   = a;  // Moves and sgnj func 3 copy A
    lt  = (order_key(a) < order_key(b)) && !(is_zero(a) && is_zero(b));
    eq  = (a == b) || (is_zero(a) && is_zero(b));
    nan = is_nan(a) || is_nan(b);
    case (op)
        FSGNJ: begin
            case (rm[1:0])
                2'd0: r[31] = b[31];
                2'd1: r[31] = ~b[31];
                2'd2: r[31] = a[31] ^ b[31];
                default: ;
            endcase
        end
        FMIN_MAX: begin
            if (is_nan(a) && is_nan(b)) r = CANON_NAN;
            else if (is_nan(a))         r = b;
            else if (is_nan(b))         r = a;
            else if (rm[0])             r = (order_key(a) < order_key(b)) ? b : a;  // Max
            else                        r = (order_key(a) < order_key(b)) ? a : b;
        end
        FCMP: begin
            r = '0;
            case (rm[1:0])
                2'd0: r[0] = !nan && (lt || eq);
                2'd1: r[0] = !nan && lt;
                2'd2: r[0] = !nan && eq;
                default: ;
            endcase
        end
        FCLASS: r = {22'd0, class_mask(a)};
        default: ;
    endcase
    return r;
endfunction

function automatic fp_status_t expected_status(input fu_op_e op, input logic [31:0] a,
                                               input logic [31:0] b, input logic [2:0] rm);
    fp_status_t s;
    s = '0;
    if (op == FMIN_MAX)
        s[NV_BIT] = is_snan(a) || is_snan(b);
    else if (op == FCMP && rm[1:0] == 2'd2)
        s[NV_BIT] = is_snan(a) || is_snan(b);  // Quiet eq
    else if (op == FCMP && rm[1:0] != 2'd3)
        s[NV_BIT] = is_nan(a) || is_nan(b);    // le and lt signal on any NaN
    return s;
endfunction

`endif

// ==== sim/tb_fpu_slice.sv ====
// ----------------------------
// Testbench for fpu_slice_top
// Table driven, random writeback back-pressure
// Stops at the first wrong value
// ----------------------------
`timescale 1ns/1ns

`include "fpu_slice_cfg.svh"

module tb_fpu_slice;
    import fpu_slice_pkg::*;

    `include "tb_fpu_ref.svh"

    localparam int LAT       = `FPU_NONCOMP_LAT;
    localparam int N_ENTRIES = 33;
    localparam int TIMEOUT   = N_ENTRIES * (LAT + 1) * 8 + 200;  // In cycles

    logic                      clk_i = 1'b0;
    logic                      rst_ni, flush_i, fpu_valid_i, fpu_ready_i;
    fu_op_e                    fu_op_i;
    logic [`FPU_FLEN-1:0]      operand_a_i, operand_b_i;
    logic [2:0]                fpu_rm_i;
    logic [`FPU_TAG_BITS-1:0]  trans_id_i;
    logic                      fpu_ready_o, fpu_valid_o;
    logic [`FPU_FLEN-1:0]      result_o;
    logic [`FPU_TAG_BITS-1:0]  fpu_trans_id_o;
    fp_status_t                fpu_status_o;

    // Stimulus table
    fu_op_e                    tbl_op [N_ENTRIES];
    logic [`FPU_FLEN-1:0]      tbl_a  [N_ENTRIES];
    logic [`FPU_FLEN-1:0]      tbl_b  [N_ENTRIES];
    logic [2:0]                tbl_rm [N_ENTRIES];
    int                        n_loaded = 0;

    // Expected results in acceptance order
    logic [`FPU_FLEN-1:0]      exp_res  [$];
    fp_status_t                exp_stat [$];
    logic [`FPU_TAG_BITS-1:0]  exp_tag  [$];
    int                        exp_cyc  [$];

    int                        cycle     = 0;
    int                        bp_mode   = 2;     // 0 low, 1 high, 2 random
    logic                      lat_check = 1'b0;
    logic [`FPU_TAG_BITS-1:0]  next_tag  = '0;

    fpu_slice_top i_dut (.*);

    always #4 clk_i = ~clk_i;

    // ----------------------------
    // Failure reporting and checks
    // ----------------------------
    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_result(input logic [`FPU_FLEN-1:0] got, input logic [`FPU_FLEN-1:0] exp);
        if (got !== exp)
            stop_run($sformatf("Mismatch at %0t ns: result_o = %h, expected %h", $time, got, exp));
    endtask

    task automatic check_status(input fp_status_t got, input fp_status_t exp);
        if (got !== exp)
            stop_run($sformatf("Mismatch at %0t ns: fpu_status_o = %b, expected %b",
                               $time, got, exp));
    endtask

    task automatic check_tag(input logic [`FPU_TAG_BITS-1:0] got,
                             input logic [`FPU_TAG_BITS-1:0] exp);
        if (got !== exp)
            stop_run($sformatf("Mismatch at %0t ns: fpu_trans_id_o = %0d, expected %0d",
                               $time, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_run($sformatf("Mismatch at %0t ns: %s = %b, expected %b", $time, name, got, exp));
    endtask

    task automatic check_latency(input int got);
        if (got != LAT)
            stop_run($sformatf("Mismatch at %0t ns: result latency = %0d, expected %0d",
                               $time, got, LAT));
    endtask

    // ----------------------------
    // Stimulus
    // ----------------------------
    task automatic add_entry(input fu_op_e op, input logic [31:0] a, input logic [31:0] b,
                             input logic [2:0] rm);
        tbl_op[n_loaded] = op;
        tbl_a[n_loaded]  = a;
        tbl_b[n_loaded]  = b;
        tbl_rm[n_loaded] = rm;
        n_loaded++;
    endtask

    task automatic drive_request(input int idx);
        fpu_valid_i = 1'b1;
        fu_op_i     = tbl_op[idx];
        operand_a_i = tbl_a[idx];
        operand_b_i = tbl_b[idx];
        fpu_rm_i    = tbl_rm[idx];
        trans_id_i  = next_tag;
    endtask

    // Valid stays up on return so requests can go back to back
    task automatic issue(input int idx);
        @(negedge clk_i);
        drive_request(idx);
        @(posedge clk_i);
        while (!fpu_ready_o) @(posedge clk_i);
        exp_res.push_back(expected_result(tbl_op[idx], tbl_a[idx], tbl_b[idx], tbl_rm[idx]));
        exp_stat.push_back(expected_status(tbl_op[idx], tbl_a[idx], tbl_b[idx], tbl_rm[idx]));
        exp_tag.push_back(next_tag);
        exp_cyc.push_back(cycle);
        next_tag = next_tag + 1'b1;  // Wraps modulo 8
    endtask

    task automatic drop_valid();
        @(negedge clk_i);
        fpu_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_tag.size() != 0) @(negedge clk_i);
    endtask

    // Park one request behind a full pipeline, then flush everything
    task automatic stall_and_flush(input int idx);
        @(negedge clk_i);
        drive_request(idx);
        @(posedge clk_i);
        check_bit("fpu_ready_o", fpu_ready_o, 1'b0);
        @(negedge clk_i);
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i     = 1'b0;
        fpu_valid_i = 1'b0;
        next_tag    = next_tag + 1'b1;
        exp_res.delete();
        exp_stat.delete();
        exp_tag.delete();
        exp_cyc.delete();
        check_bit("fpu_valid_o", fpu_valid_o, 1'b0);
        check_bit("fpu_ready_o", fpu_ready_o, 1'b1);  // Buffer back in READY
    endtask

    task automatic load_table();
        // Sign injection and moves, rm 6 also checks that bit 2 is ignored
        add_entry(FSGNJ,    32'h3f800000, 32'hc0000000, 3'd0);
        add_entry(FSGNJ,    32'hc0000000, 32'h3f800000, 3'd1);
        add_entry(FSGNJ,    32'hbf000000, 32'hc0000000, 3'd2);
        add_entry(FSGNJ,    32'h7fc00000, 32'hc0000000, 3'd0);
        add_entry(FSGNJ,    32'h7f800001, 32'h3f800000, 3'd6);
        add_entry(FMV_F2X,  32'hc0000000, 32'h3f800000, 3'd0);
        add_entry(FMV_X2F,  32'hffc00001, 32'h00000000, 3'd1);
        // Min / max
        add_entry(FMIN_MAX, 32'h3f800000, 32'hc0000000, 3'd0);
        add_entry(FMIN_MAX, 32'h3f800000, 32'h40200000, 3'd1);
        add_entry(FMIN_MAX, 32'h00000000, 32'h80000000, 3'd0);
        add_entry(FMIN_MAX, 32'h80000000, 32'h00000000, 3'd1);
        add_entry(FMIN_MAX, 32'h7fc00000, 32'hbf000000, 3'd0);
        add_entry(FMIN_MAX, 32'hffc00001, 32'h7fc00000, 3'd1);  // Both NaN
        add_entry(FMIN_MAX, 32'h7f800001, 32'h40400000, 3'd1);
        add_entry(FMIN_MAX, 32'hc0000000, 32'hbf000000, 3'd0);
        // Compare
        add_entry(FCMP,     32'h3f800000, 32'h40200000, 3'd0);
        add_entry(FCMP,     32'h40200000, 32'h40200000, 3'd1);
        add_entry(FCMP,     32'h80000000, 32'h00000000, 3'd2);
        add_entry(FCMP,     32'h00000000, 32'h80000000, 3'd1);
        add_entry(FCMP,     32'h7fc00000, 32'h3f800000, 3'd0);
        add_entry(FCMP,     32'h3f800000, 32'h7fc00000, 3'd2);
        add_entry(FCMP,     32'h7f800001, 32'h3f800000, 3'd2);
        add_entry(FCMP,     32'hc0000000, 32'hbf000000, 3'd1);
        // One per class, -inf up to quiet NaN
        add_entry(FCLASS,   32'hff800000, 32'h0, 3'd0);
        add_entry(FCLASS,   32'hc0000000, 32'h0, 3'd0);
        add_entry(FCLASS,   32'h807fffff, 32'h0, 3'd0);
        add_entry(FCLASS,   32'h80000000, 32'h0, 3'd0);
        add_entry(FCLASS,   32'h00000000, 32'h0, 3'd0);
        add_entry(FCLASS,   32'h00000001, 32'h0, 3'd0);
        add_entry(FCLASS,   32'h3f800000, 32'h0, 3'd0);
        add_entry(FCLASS,   32'h7f800000, 32'h0, 3'd0);
        add_entry(FCLASS,   32'h7f800001, 32'h0, 3'd0);
        add_entry(FCLASS,   32'h7fc00000, 32'h0, 3'd0);
    endtask

    // ----------------------------
    // Back-pressure, scoreboard, timeout
    // ----------------------------
    always @(negedge clk_i) begin : p_backpressure
        case (bp_mode)
            0:       fpu_ready_i = 1'b0;
            1:       fpu_ready_i = 1'b1;
            default: fpu_ready_i = ($urandom % 10) < 7;  // About 70 percent high
        endcase
    end

    always @(posedge clk_i) begin : p_scoreboard
        int accepted_at;
        if (rst_ni && fpu_valid_o && fpu_ready_i) begin
            if (exp_tag.size() == 0) begin
                stop_run("Result arrived with no request pending");
            end else begin
                check_tag(fpu_trans_id_o, exp_tag.pop_front());
                check_result(result_o, exp_res.pop_front());
                check_status(fpu_status_o, exp_stat.pop_front());
                accepted_at = exp_cyc.pop_front();
                if (lat_check) check_latency(cycle - accepted_at);
            end
        end
    end

    always @(posedge clk_i) begin : p_cycles
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT) stop_run("Timeout, run did not finish within the cycle limit");
    end

    initial begin : p_main
        void'($urandom(32'heb07d0e6));
        rst_ni      = 1'b0;
        flush_i     = 1'b0;
        fpu_valid_i = 1'b0;
        fpu_ready_i = 1'b0;
        fu_op_i     = FSGNJ;
        operand_a_i = '0;
        operand_b_i = '0;
        fpu_rm_i    = '0;
        trans_id_i  = '0;
        load_table();
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        check_bit("fpu_valid_o", fpu_valid_o, 1'b0);
        check_bit("fpu_ready_o", fpu_ready_o, 1'b1);

        // Whole table under random writeback stalls
        for (int i = 0; i < N_ENTRIES; i++) issue(i);
        drop_valid();
        wait_drain();

        // Writeback always ready, fixed latency
        bp_mode = 1;
        @(negedge clk_i);
        lat_check = 1'b1;
        for (int i = 0; i < N_ENTRIES; i++) issue(i);
        drop_valid();
        wait_drain();
        lat_check = 1'b0;

        // Fill every stage with writeback held off, park one more and flush
        bp_mode = 0;
        @(negedge clk_i);
        for (int i = 0; i < LAT; i++) issue(i);
        stall_and_flush(LAT);
        bp_mode = 1;
        @(negedge clk_i);
        issue(0);
        drop_valid();
        wait_drain();
        repeat (2 * LAT) @(negedge clk_i);  // Flushed tags must not show up late

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== src/fpu_slice_top.sv ====
// ----------------------------
// FP32 non-computational slice
// Results leave in issue order, flush drops all in flight
// ----------------------------
`timescale 1ns/1ns

`include "fpu_slice_cfg.svh"

module fpu_slice_top (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       flush_i,
    input  logic                       fpu_valid_i,
    input  fpu_slice_pkg::fu_op_e      fu_op_i,
    input  logic [`FPU_FLEN-1:0]       operand_a_i,
    input  logic [`FPU_FLEN-1:0]       operand_b_i,
    input  logic [2:0]                 fpu_rm_i,
    input  logic [`FPU_TAG_BITS-1:0]   trans_id_i,
    input  logic                       fpu_ready_i,
    output logic                       fpu_ready_o,
    output logic                       fpu_valid_o,
    output logic [`FPU_FLEN-1:0]       result_o,
    output logic [`FPU_TAG_BITS-1:0]   fpu_trans_id_o,
    output fpu_slice_pkg::fp_status_t  fpu_status_o
);
    import fpu_slice_pkg::*;

    // Decoded request
    unit_op_e                 dec_op;
    logic [1:0]               dec_func;
    logic                     dec_pass;

    // Buffer to unit
    logic                     unit_valid, unit_ready;
    unit_op_e                 unit_op;
    logic [1:0]               unit_func;
    logic                     unit_pass;
    logic [`FPU_FLEN-1:0]     unit_a, unit_b;
    logic [`FPU_TAG_BITS-1:0] unit_tag;

    fpu_op_decode i_decode (
        .fu_op_i    (fu_op_i),
        .rm_i       (fpu_rm_i),
        .unit_op_o  (dec_op),
        .func_o     (dec_func),
        .passthru_o (dec_pass)
    );

    fpu_issue_buffer i_issue (
        .clk_i, .rst_ni, .flush_i,
        .valid_i      (fpu_valid_i),
        .unit_op_i    (dec_op),
        .func_i       (dec_func),
        .passthru_i   (dec_pass),
        .operand_a_i  (operand_a_i),
        .operand_b_i  (operand_b_i),
        .tag_i        (trans_id_i),
        .unit_ready_i (unit_ready),
        .ready_o      (fpu_ready_o),
        .unit_valid_o (unit_valid),
        .unit_op_o    (unit_op),
        .func_o       (unit_func),
        .passthru_o   (unit_pass),
        .operand_a_o  (unit_a),
        .operand_b_o  (unit_b),
        .tag_o        (unit_tag)
    );

    fpu_noncomp_unit i_unit (
        .clk_i, .rst_ni, .flush_i,
        .in_valid_i  (unit_valid),
        .unit_op_i   (unit_op),
        .func_i      (unit_func),
        .passthru_i  (unit_pass),
        .operand_a_i (unit_a),
        .operand_b_i (unit_b),
        .tag_i       (unit_tag),
        .out_ready_i (fpu_ready_i),  // Writeback back-pressure
        .in_ready_o  (unit_ready),
        .out_valid_o (fpu_valid_o),
        .result_o    (result_o),
        .tag_o       (fpu_trans_id_o),
        .status_o    (fpu_status_o)
    );

endmodule

// ==== src/fpu_noncomp_unit.sv ====
// ----------------------------
// FP32 sign injection, min/max, compare and classify
// Result is formed at entry, then rides FPU_NONCOMP_LAT stallable stages
// ----------------------------
`timescale 1ns/1ns

`include "fpu_slice_cfg.svh"

module fpu_noncomp_unit (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       flush_i,
    input  logic                       in_valid_i,
    input  fpu_slice_pkg::unit_op_e    unit_op_i,
    input  logic [1:0]                 func_i,
    input  logic                       passthru_i,
    input  logic [`FPU_FLEN-1:0]       operand_a_i,
    input  logic [`FPU_FLEN-1:0]       operand_b_i,
    input  logic [`FPU_TAG_BITS-1:0]   tag_i,
    input  logic                       out_ready_i,
    output logic                       in_ready_o,
    output logic                       out_valid_o,
    output logic [`FPU_FLEN-1:0]       result_o,
    output logic [`FPU_TAG_BITS-1:0]   tag_o,
    output fpu_slice_pkg::fp_status_t  status_o
);
    import fpu_slice_pkg::*;

    localparam int unsigned LAT = `FPU_NONCOMP_LAT;
    localparam int unsigned W   = `FPU_FLEN;

    // One-hot class mask in RISC-V fclass order
    function automatic logic [9:0] fp_class(input logic [W-1:0] x);
        logic        sgn;
        logic [7:0]  exp;
        logic [22:0] man;
        sgn      = x[W-1];
        exp      = x[30:23];
        man      = x[22:0];
        fp_class = '0;
        if (exp == 8'hff) begin
            if (man == '0)   fp_class[sgn ? 0 : 7] = 1'b1;  // Infinity
            else if (man[22]) fp_class[9] = 1'b1;           // Quiet NaN
            else             fp_class[8] = 1'b1;            // Signaling NaN
        end else if (exp == '0) begin
            if (man == '0) fp_class[sgn ? 3 : 4] = 1'b1;  // Zero
            else           fp_class[sgn ? 2 : 5] = 1'b1;  // Subnormal
        end else begin
            fp_class[sgn ? 1 : 6] = 1'b1;
        end
    endfunction

    // ----------------------------
    // Operand classes
    // ----------------------------
    logic [9:0] class_a, class_b;
    logic       a_nan, b_nan, any_nan, any_snan;
    logic       both_zero;
    logic       a_lt_b;  // Total order, -0 below +0
    logic       lt_cmp, eq_cmp;

    assign class_a   = fp_class(operand_a_i);
    assign class_b   = fp_class(operand_b_i);
    assign a_nan     = class_a[8] | class_a[9];
    assign b_nan     = class_b[8] | class_b[9];
    assign any_nan   = a_nan | b_nan;
    assign any_snan  = class_a[8] | class_b[8];
    assign both_zero = (class_a[3] | class_a[4]) & (class_b[3] | class_b[4]);

    always_comb begin : p_order
        if (operand_a_i[W-1] != operand_b_i[W-1])
            a_lt_b = operand_a_i[W-1];                            // Negative one is lower
        else if (operand_a_i[W-1])
            a_lt_b = operand_a_i[W-2:0] > operand_b_i[W-2:0];  // Both negative
        else
            a_lt_b = operand_a_i[W-2:0] < operand_b_i[W-2:0];
    end

    // IEEE compare treats the two zeros as equal
    assign lt_cmp = a_lt_b & ~both_zero;
    assign eq_cmp = (operand_a_i == operand_b_i) | both_zero;

    // ----------------------------
    // Operation evaluation
    // ----------------------------
    logic [W-1:0] res_d;
    fp_status_t   stat_d;

    always_comb begin : p_eval
        res_d  = operand_a_i;
        stat_d = '0;
        unique case (unit_op_i)
            SGNJ: begin
                if (!passthru_i) begin
                    unique case (func_i)
                        2'd0: res_d[W-1] = operand_b_i[W-1];
                        2'd1: res_d[W-1] = ~operand_b_i[W-1];
                        2'd2: res_d[W-1] = operand_a_i[W-1] ^ operand_b_i[W-1];
                        default: ;  // Plain copy of A
                    endcase
                end
            end
            MINMAX: begin
                stat_d[NV_BIT] = any_snan;
                if (a_nan && b_nan) res_d = CANON_NAN;
                else if (a_nan)     res_d = operand_b_i;
                else if (b_nan)     res_d = operand_a_i;
                else                res_d = (a_lt_b ^ func_i[0]) ? operand_a_i : operand_b_i;
            end
            CMP: begin
                res_d = '0;
                unique case (func_i)
                    2'd0: begin
                        res_d[0]       = ~any_nan & (lt_cmp | eq_cmp);
                        stat_d[NV_BIT] = any_nan;  // Signaling compare
                    end
                    2'd1: begin
                        res_d[0]       = ~any_nan & lt_cmp;
                        stat_d[NV_BIT] = any_nan;
                    end
                    2'd2: begin
                        res_d[0]       = ~any_nan & eq_cmp;
                        stat_d[NV_BIT] = any_snan;  // Quiet compare
                    end
                    default: ;
                endcase
            end
            CLASSIFY: res_d = {{(W-10){1'b0}}, class_a};
            default:  ;
        endcase
    end

    // ----------------------------
    // Stallable pipeline
    // ----------------------------
    logic [LAT:0]             stage_rdy;  // Stage may load, LAT is the sink
    logic [LAT-1:0]           valid_q, valid_s;
    logic [W-1:0]             res_q  [LAT];
    logic [W-1:0]             res_s  [LAT];
    fp_status_t               stat_q [LAT];
    fp_status_t               stat_s [LAT];
    logic [`FPU_TAG_BITS-1:0] tag_q  [LAT];
    logic [`FPU_TAG_BITS-1:0] tag_s  [LAT];

    always_comb begin : p_chain
        stage_rdy[LAT] = out_ready_i;
        for (int i = LAT - 1; i >= 0; i--) begin
            stage_rdy[i] = ~valid_q[i] | stage_rdy[i+1];  // Empty or moving on
        end
        valid_s[0] = in_valid_i;
        res_s[0]   = res_d;
        stat_s[0]  = stat_d;
        tag_s[0]   = tag_i;
        for (int i = 1; i < LAT; i++) begin
            valid_s[i] = valid_q[i-1];
            res_s[i]   = res_q[i-1];
            stat_s[i]  = stat_q[i-1];
            tag_s[i]   = tag_q[i-1];
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;  // Drop everything in flight
        end else begin
            for (int i = 0; i < LAT; i++) begin
                if (stage_rdy[i]) valid_q[i] <= valid_s[i];
            end
        end
    end

    always_ff @(posedge clk_i) begin : p_data
        for (int i = 0; i < LAT; i++) begin
            if (stage_rdy[i] && valid_s[i]) begin
                res_q[i]  <= res_s[i];
                stat_q[i] <= stat_s[i];
                tag_q[i]  <= tag_s[i];
            end
        end
    end

    assign in_ready_o  = stage_rdy[0];
    assign out_valid_o = valid_q[LAT-1];
    assign result_o    = res_q[LAT-1];
    assign status_o    = stat_q[LAT-1];
    assign tag_o       = tag_q[LAT-1];

    a_out_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        out_valid_o && !out_ready_i && !flush_i |=>
            out_valid_o && $stable(result_o) && $stable(status_o) && $stable(tag_o));

endmodule

// ==== src/fpu_issue_buffer.sv ====
// ----------------------------
// Issue buffer between core and unit
// One skid slot, upstream ready may depend on valid_i
// Flush drops the parked request and consumes the one on the bus
// ----------------------------
`timescale 1ns/1ns

`include "fpu_slice_cfg.svh"

module fpu_issue_buffer (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      flush_i,
    input  logic                      valid_i,
    input  fpu_slice_pkg::unit_op_e   unit_op_i,
    input  logic [1:0]                func_i,
    input  logic                      passthru_i,
    input  logic [`FPU_FLEN-1:0]      operand_a_i,
    input  logic [`FPU_FLEN-1:0]      operand_b_i,
    input  logic [`FPU_TAG_BITS-1:0]  tag_i,
    input  logic                      unit_ready_i,
    output logic                      ready_o,
    output logic                      unit_valid_o,
    output fpu_slice_pkg::unit_op_e   unit_op_o,
    output logic [1:0]                func_o,
    output logic                      passthru_o,
    output logic [`FPU_FLEN-1:0]      operand_a_o,
    output logic [`FPU_FLEN-1:0]      operand_b_o,
    output logic [`FPU_TAG_BITS-1:0]  tag_o
);
    import fpu_slice_pkg::*;

    issue_state_e state_q, state_d;
    logic         hold_en;   // Capture request into hold register
    logic         use_hold;  // Feed unit from hold register

    // Hold register
    unit_op_e                 op_q;
    logic [1:0]               func_q;
    logic                     pass_q;
    logic [`FPU_FLEN-1:0]     a_q;
    logic [`FPU_FLEN-1:0]     b_q;
    logic [`FPU_TAG_BITS-1:0] tag_q;

    // ----------------------------
    // READY / STALL machine
    // ----------------------------
    always_comb begin : p_issue_fsm
        ready_o      = 1'b0;
        unit_valid_o = 1'b0;
        hold_en      = 1'b0;
        use_hold     = 1'b0;
        state_d      = state_q;

        unique case (state_q)
            READY: begin
                ready_o      = 1'b1;
                unit_valid_o = valid_i;  // Bypass to the unit
                // Unit busy, park the request and stop the issuer
                if (valid_i && !unit_ready_i) begin
                    ready_o = 1'b0;
                    hold_en = 1'b1;
                    state_d = STALL;
                end
            end
            STALL: begin
                unit_valid_o = 1'b1;
                use_hold     = 1'b1;
                if (unit_ready_i) begin
                    ready_o = 1'b1;  // Parked request taken, release issuer
                    state_d = READY;
                end
            end
            default: ;
        endcase

        // Flush wins, whatever is on the bus is taken and thrown away
        if (flush_i) begin
            ready_o = 1'b1;
            hold_en = 1'b0;
            state_d = READY;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
        if (!rst_ni) begin
            state_q <= READY;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin : p_hold
        if (hold_en) begin
            op_q   <= unit_op_i;
            func_q <= func_i;
            pass_q <= passthru_i;
            a_q    <= operand_a_i;
            b_q    <= operand_b_i;
            tag_q  <= tag_i;
        end
    end

    // Held or direct request towards the unit
    assign unit_op_o   = use_hold ? op_q   : unit_op_i;
    assign func_o      = use_hold ? func_q : func_i;
    assign passthru_o  = use_hold ? pass_q : passthru_i;
    assign operand_a_o = use_hold ? a_q    : operand_a_i;
    assign operand_b_o = use_hold ? b_q    : operand_b_i;
    assign tag_o       = use_hold ? tag_q  : tag_i;

    // ----------------------------
    // Checks
    // ----------------------------
    // Every upstream transfer is also taken by the unit
    a_stall_blocks: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_i && ready_o && !flush_i |-> unit_valid_o && unit_ready_i);

    // Parked copy matches the request the issuer keeps on the bus
    a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (state_q == STALL) && !flush_i |->
            {op_q, func_q, pass_q, a_q, b_q, tag_q} ==
            {unit_op_i, func_i, passthru_i, operand_a_i, operand_b_i, tag_i});

endmodule

// ==== src/fpu_op_decode.sv ====
// ----------------------------
// Core opcode to unit op translation
// Purely combinational, rm bit 2 is ignored
// ----------------------------
`timescale 1ns/1ns

module fpu_op_decode (
    input  fpu_slice_pkg::fu_op_e   fu_op_i,
    input  logic [2:0]              rm_i,
    output fpu_slice_pkg::unit_op_e unit_op_o,
    output logic [1:0]              func_o,
    output logic                    passthru_o
);
    import fpu_slice_pkg::*;

    logic [1:0] rm_masked;  // AH bit dropped

    assign rm_masked = rm_i[1:0];

    always_comb begin : p_translate
        // Defaults give a plain copy of operand A
        unit_op_o  = SGNJ;
        func_o     = rm_masked;
        passthru_o = 1'b0;

        unique case (fu_op_i)
            FSGNJ:    unit_op_o = SGNJ;      // sgnj / sgnjn / sgnjx in func
            FMIN_MAX: unit_op_o = MINMAX;    // func[0] picks max
            FCMP:     unit_op_o = CMP;       // le / lt / eq in func
            FCLASS:   unit_op_o = CLASSIFY;  // func is don't care here
            // Moves need no recoding, A goes through unchanged
            FMV_F2X, FMV_X2F: begin
                unit_op_o  = SGNJ;
                func_o     = 2'b11;
                passthru_o = 1'b1;
            end
            default: passthru_o = 1'b1;  // Unknown code acts as a move
        endcase
    end

endmodule

// ==== src/fpu_slice_pkg.sv ====
// ----------------------------
// Opcodes, unit ops and flag layout of the FP slice
// Status flags follow the RISC-V fflags order
// ----------------------------
package fpu_slice_pkg;

    // Core opcodes, only the non-computational subset
    typedef enum logic [2:0] {
        FSGNJ    = 3'd0,
        FMIN_MAX = 3'd1,
        FCMP     = 3'd2,
        FCLASS   = 3'd3,
        FMV_F2X  = 3'd4,
        FMV_X2F  = 3'd5
    } fu_op_e;

    // Operations of the built-in unit
    typedef enum logic [1:0] {
        SGNJ     = 2'd0,
        MINMAX   = 2'd1,
        CMP      = 2'd2,
        CLASSIFY = 2'd3
    } unit_op_e;

    // Issue buffer state
    typedef enum logic {
        READY = 1'b0,  // Bypass, requests go straight to the unit
        STALL = 1'b1   // Request parked in the hold register
    } issue_state_e;

    // ----------------------------
    // Exception flags
    // ----------------------------
    typedef logic [4:0] fp_status_t;  // {NV, DZ, OF, UF, NX}

    localparam int unsigned NV_BIT = 4;  // Invalid operation
    localparam int unsigned DZ_BIT = 3;  // Divide by zero
    localparam int unsigned OF_BIT = 2;  // Overflow
    localparam int unsigned UF_BIT = 1;  // Underflow
    localparam int unsigned NX_BIT = 0;  // Inexact

    // Canonical quiet NaN for FP32
    localparam logic [31:0] CANON_NAN = 32'h7fc00000;

endpackage

// ==== src/fpu_slice_cfg.svh ====
// ----------------------------
// Build-time sizes of the FP slice
// FPU_FLEN must stay 32, only FP32 is handled
// FPU_NONCOMP_LAT must be 1 or more
// ----------------------------
`ifndef FPU_SLICE_CFG_SVH
`define FPU_SLICE_CFG_SVH

// Operand and result width
`define FPU_FLEN 32

// Transaction ID width
`define FPU_TAG_BITS 3

// Register stages in the non-computational unit
`define FPU_NONCOMP_LAT 2

`endif
